//--- logic/fb_pkg.sv
`default_nettype none

package fb_pkg;

  // Pixel format.
  localparam int PIXEL_WIDTH = 4;

  // Frame geometry.
  localparam int FRAME_W = 16;
  localparam int FRAME_H = 8;
  localparam int FRAME_PIXELS = FRAME_W * FRAME_H;
  localparam int ADDR_LEN = $clog2(FRAME_PIXELS);

  // Address to data, in cycles.
  localparam int RAM_LATENCY = 2;

  typedef logic [PIXEL_WIDTH-1:0] pixel_t;

  // Raster address, row * FRAME_W + column.
  typedef logic [ADDR_LEN-1:0] addr_t;

endpackage

`default_nettype wire

//--- logic/fb_write_if.sv
`default_nettype none
`timescale 1ns/1ps

interface fb_write_if;

  logic write_enable;
  fb_pkg::addr_t write_addr;
  fb_pkg::pixel_t write_data;
  // One-cycle pulse, only with the write of address 0 of a new frame.
  logic swap_buffers;

  modport writer (
    output write_enable,
    output write_addr,
    output write_data,
    output swap_buffers
  );

  modport manager (
    input write_enable,
    input write_addr,
    input write_data,
    input swap_buffers
  );

endinterface

`default_nettype wire

//--- logic/frame_ram.sv
`default_nettype none
`timescale 1ns/1ps

module frame_ram (
  input wire logic clk,
  input wire logic write_enable,
  input wire fb_pkg::addr_t write_addr,
  input wire fb_pkg::pixel_t write_data,
  input wire fb_pkg::addr_t read_addr,
  output fb_pkg::pixel_t read_data
);

  // Contents start at zero.
  fb_pkg::pixel_t mem [fb_pkg::FRAME_PIXELS] = '{default: '0};

  // First read stage, taken before any same-cycle write lands.
  fb_pkg::pixel_t ram_data = '0;
  fb_pkg::pixel_t out_data = '0;

  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[write_addr] <= write_data;
    end
  end

  // Read first.
  always_ff @(posedge clk) begin
    ram_data <= mem[read_addr];
  end

  // Output register, second cycle of latency.
  always_ff @(posedge clk) begin
    out_data <= ram_data;
  end

  assign read_data = out_data;

  write_addr_in_range: assert property (
    @(posedge clk) write_enable |-> (write_addr < fb_pkg::FRAME_PIXELS)
  ) else $error("frame_ram write address %0d out of range", write_addr);

endmodule

`default_nettype wire

//--- logic/bram_manager.sv
`default_nettype none
`timescale 1ns/1ps

module bram_manager (
  input wire logic clk,
  input wire logic rst,
  fb_write_if.manager wr,
  input wire fb_pkg::addr_t read_addr,
  output fb_pkg::pixel_t read_data,
  output logic which_bram
);

  fb_pkg::pixel_t ram0_data;
  fb_pkg::pixel_t ram1_data;

  // Role bit names the back buffer.
  logic which_bram_in;
  logic which_bram_mid;
  logic which_bram_end;

  // A swapping write already goes to the new back buffer.
  assign which_bram_in = wr.swap_buffers ? !which_bram_mid : which_bram_mid;

  // Two stages, so the select follows the returning data.
  always_ff @(posedge clk) begin
    if (rst) begin
      which_bram_mid <= 1'b0;
      which_bram_end <= 1'b0;
    end else begin
      which_bram_mid <= which_bram_in;
      which_bram_end <= which_bram_mid;
    end
  end

  // Front buffer is the other one.
  assign which_bram = !which_bram_end;
  assign read_data = which_bram ? ram1_data : ram0_data;

  frame_ram bram0 (
    .clk(clk),
    .write_enable(wr.write_enable && (which_bram_in == 1'b0)),
    .write_addr(wr.write_addr),
    .write_data(wr.write_data),
    .read_addr(read_addr),
    .read_data(ram0_data)
  );

  frame_ram bram1 (
    .clk(clk),
    .write_enable(wr.write_enable && (which_bram_in == 1'b1)),
    .write_addr(wr.write_addr),
    .write_data(wr.write_data),
    .read_addr(read_addr),
    .read_data(ram1_data)
  );

  // Writer must pair the swap with a write.
  swap_with_write: assert property (
    @(posedge clk) disable iff (rst)
    wr.swap_buffers |-> wr.write_enable
  ) else $error("swap_buffers high without write_enable");

endmodule

`default_nettype wire

//--- logic/frame_writer.sv
`default_nettype none
`timescale 1ns/1ps

module frame_writer (
  input wire logic clk,
  input wire logic rst,
  input wire logic pixel_valid,
  input wire fb_pkg::pixel_t pixel_data,
  fb_write_if.writer wr
);

  fb_pkg::addr_t wr_count;
  logic first_frame_done;
  logic count_last;

  assign count_last = (wr_count == fb_pkg::addr_t'(fb_pkg::FRAME_PIXELS - 1));

  // Raster counter, one step per accepted pixel.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_count <= '0;
      first_frame_done <= 1'b0;
    end else if (pixel_valid) begin
      if (count_last) begin
        wr_count <= '0;
        first_frame_done <= 1'b1;
      end else begin
        wr_count <= wr_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr.write_enable <= 1'b0;
      wr.swap_buffers <= 1'b0;
    end else begin
      wr.write_enable <= pixel_valid;
      // No swap into the very first frame.
      wr.swap_buffers <= pixel_valid && (wr_count == '0) && first_frame_done;
    end
  end

  // Payload.
  always_ff @(posedge clk) begin
    wr.write_addr <= wr_count;
    wr.write_data <= pixel_data;
  end

  write_addr_in_range: assert property (
    @(posedge clk) disable iff (rst)
    wr.write_enable |-> (wr.write_addr < fb_pkg::FRAME_PIXELS)
  ) else $error("frame_writer write address %0d out of range", wr.write_addr);

endmodule

`default_nettype wire

//--- logic/scan_reader.sv
`default_nettype none
`timescale 1ns/1ps

module scan_reader (
  input wire logic clk,
  input wire logic rst,
  input wire logic scan_enable,
  output fb_pkg::addr_t read_addr,
  output logic out_valid,
  output logic out_frame_start
);

  fb_pkg::addr_t rd_count;
  logic [fb_pkg::RAM_LATENCY-1:0] valid_pipe;
  logic [fb_pkg::RAM_LATENCY-1:0] start_pipe;
  logic count_last;

  assign count_last = (rd_count == fb_pkg::addr_t'(fb_pkg::FRAME_PIXELS - 1));

  // Holds while paused.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_count <= '0;
    end else if (scan_enable) begin
      if (count_last) begin
        rd_count <= '0;
      end else begin
        rd_count <= rd_count + 1'b1;
      end
    end
  end

  assign read_addr = rd_count;

  // Marks travel alongside the RAM read.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_pipe <= '0;
      start_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[fb_pkg::RAM_LATENCY-2:0], scan_enable};
      start_pipe <= {start_pipe[fb_pkg::RAM_LATENCY-2:0], scan_enable && (rd_count == '0)};
    end
  end

  assign out_valid = valid_pipe[fb_pkg::RAM_LATENCY-1];
  assign out_frame_start = start_pipe[fb_pkg::RAM_LATENCY-1];

endmodule

`default_nettype wire

//--- logic/frame_buffer_top.sv
`default_nettype none
`timescale 1ns/1ps

module frame_buffer_top (
  input wire logic clk,
  input wire logic rst,
  input wire logic pixel_valid,
  input wire fb_pkg::pixel_t pixel_data,
  input wire logic scan_enable,
  output fb_pkg::pixel_t out_pixel,
  output logic out_valid,
  output logic out_frame_start,
  output logic out_buffer
);

  fb_pkg::addr_t read_addr;

  // Write side and swap strobe.
  fb_write_if wr_bus ();

  frame_writer frame_writer_i (
    .clk(clk),
    .rst(rst),
    .pixel_valid(pixel_valid),
    .pixel_data(pixel_data),
    .wr(wr_bus.writer)
  );

  bram_manager bram_manager_i (
    .clk(clk),
    .rst(rst),
    .wr(wr_bus.manager),
    .read_addr(read_addr),
    .read_data(out_pixel),
    .which_bram(out_buffer)
  );

  scan_reader scan_reader_i (
    .clk(clk),
    .rst(rst),
    .scan_enable(scan_enable),
    .read_addr(read_addr),
    .out_valid(out_valid),
    .out_frame_start(out_frame_start)
  );

endmodule

`default_nettype wire

//--- dv/frame_buffer_tb.sv
`default_nettype none
`timescale 1ns/1ps

module frame_buffer_tb;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_TESTS = 7;
  localparam logic [31:0] LFSR_SEED = 32'haeda;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic pixel_valid = 1'b0;
  fb_pkg::pixel_t pixel_data = '0;
  logic scan_enable = 1'b0;
  fb_pkg::pixel_t out_pixel;
  logic out_valid;
  logic out_frame_start;
  logic out_buffer;

  // One row per test.
  string row_name [NUM_TESTS] = '{"empty_scan", "frame_a_hidden", "first_pixel_b_swaps",
    "frame_b_shown", "gapped_frame", "gapped_two_frames", "paused_scan"};
  int row_pixels [NUM_TESTS] = '{0, fb_pkg::FRAME_PIXELS, 1, fb_pkg::FRAME_PIXELS,
    fb_pkg::FRAME_PIXELS, 2 * fb_pkg::FRAME_PIXELS, 0};
  bit row_gaps [NUM_TESTS] = '{0, 0, 0, 0, 1, 1, 0};
  bit row_scan [NUM_TESTS] = '{1, 1, 1, 1, 1, 0, 1};
  bit row_pauses [NUM_TESTS] = '{0, 0, 0, 0, 1, 0, 1};
  bit row_buffer [NUM_TESTS] = '{1, 1, 0, 1, 0, 0, 0};

  // Reference model of both buffers.
  fb_pkg::pixel_t model_mem [2][fb_pkg::FRAME_PIXELS];
  int model_count = 0;
  bit model_first_done = 1'b0;
  bit model_role = 1'b0;

  logic [31:0] lfsr_state = LFSR_SEED;
  int error_count = 0;
  int tests_run = 0;
  int tests_bad = 0;

  frame_buffer_top frame_buffer_top_i (
    .clk(clk),
    .rst(rst),
    .pixel_valid(pixel_valid),
    .pixel_data(pixel_data),
    .scan_enable(scan_enable),
    .out_pixel(out_pixel),
    .out_valid(out_valid),
    .out_frame_start(out_frame_start),
    .out_buffer(out_buffer)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic next_random_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? LFSR_TAPS : 32'h0);
    return out;
  endfunction

  function automatic fb_pkg::pixel_t random_pixel();
    fb_pkg::pixel_t pix;
    for (int i = 0; i < fb_pkg::PIXEL_WIDTH; i++) begin
      pix[i] = next_random_bit();
    end
    return pix;
  endfunction

  function automatic void model_write(input fb_pkg::pixel_t pix);
    // New frame after the first goes to the other buffer.
    if (model_count == 0 && model_first_done) begin
      model_role = !model_role;
    end
    model_mem[model_role][model_count] = pix;
    if (model_count == fb_pkg::FRAME_PIXELS - 1) begin
      model_count = 0;
      model_first_done = 1'b1;
    end else begin
      model_count++;
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic write_pixels(input int count, input bit with_gaps);
    int sent;
    fb_pkg::pixel_t pix;
    logic [1:0] gap_bits;
    sent = 0;
    while (sent < count) begin
      @(posedge clk);
      gap_bits = 2'b11;
      if (with_gaps) begin
        gap_bits[0] = next_random_bit();
        gap_bits[1] = next_random_bit();
      end
      if (gap_bits == 2'b00) begin
        pixel_valid <= 1'b0;
      end else begin
        pix = random_pixel();
        pixel_valid <= 1'b1;
        pixel_data <= pix;
        model_write(pix);
        sent++;
      end
    end
    @(posedge clk);
    pixel_valid <= 1'b0;
  endtask

  task automatic scan_frame(input bit with_pauses);
    int got;
    bit started;
    logic en;
    logic [1:0] en_hist;
    logic [1:0] pause_bits;
    got = 0;
    started = 1'b0;
    en_hist = 2'b00;
    while (got < fb_pkg::FRAME_PIXELS) begin
      @(posedge clk);
      pause_bits = 2'b11;
      if (with_pauses) begin
        pause_bits[0] = next_random_bit();
        pause_bits[1] = next_random_bit();
      end
      en = (pause_bits != 2'b00);
      scan_enable <= en;
      @(negedge clk);
      // Valid follows the enable of two cycles back.
      check_value("out_valid", out_valid, en_hist[1]);
      if (out_valid && (started || out_frame_start)) begin
        started = 1'b1;
        check_value("out_frame_start", out_frame_start, got == 0);
        check_value($sformatf("out_pixel[%0d]", got), out_pixel,
                    model_mem[!model_role][got]);
        got++;
      end
      en_hist = {en_hist[0], en};
    end
    @(posedge clk);
    scan_enable <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("out_valid", out_valid, 1'b0);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
    end
  endtask

  initial begin : watchdog
    longint limit_cycles;
    limit_cycles = 20;
    for (int i = 0; i < NUM_TESTS; i++) begin
      limit_cycles += row_pixels[i] + 2 * fb_pkg::FRAME_PIXELS;
    end
    limit_cycles *= 2;
    #(limit_cycles * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not finish", limit_cycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin : main_sequence
    int errors_before;
    for (int b = 0; b < 2; b++) begin
      for (int a = 0; a < fb_pkg::FRAME_PIXELS; a++) begin
        model_mem[b][a] = '0;
      end
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    errors_before = error_count;
    check_value("out_valid", out_valid, 1'b0);
    check_value("out_frame_start", out_frame_start, 1'b0);
    check_value("out_buffer", out_buffer, 1'b1);
    report_test("reset_outputs", errors_before);
    for (int t = 0; t < NUM_TESTS; t++) begin
      errors_before = error_count;
      write_pixels(row_pixels[t], row_gaps[t]);
      // Swap reaches out_buffer three cycles after the pixel.
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_value("out_buffer", out_buffer, row_buffer[t]);
      check_value("out_buffer", out_buffer, !model_role);
      if (row_scan[t]) begin
        scan_frame(row_pauses[t]);
      end
      report_test(row_name[t], errors_before);
    end
    $display("%0d tests run, %0d with errors, %0d check errors",
             tests_run, tests_bad, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
logic/fb_pkg.sv
logic/fb_write_if.sv
logic/frame_ram.sv
logic/bram_manager.sv
logic/frame_writer.sv
logic/scan_reader.sv
logic/frame_buffer_top.sv
dv/frame_buffer_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the frame buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module frame_buffer_tb -f build.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vframe_buffer_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
